//--- hw/dsp_pkg.sv
`default_nettype none

package dsp_pkg;

	//////////////////////////////////////////////////////////////////////
	// bfloat16 format
	//////////////////////////////////////////////////////////////////////

	localparam int BF16_EXP_W = 8;     // Exponent bits
	localparam int BF16_MAN_W = 7;     // Stored mantissa bits, hidden one not stored
	localparam int BF16_BIAS  = 127;   // Exponent bias

	//////////////////////////////////////////////////////////////////////
	// Dot product lanes
	//////////////////////////////////////////////////////////////////////

	localparam int FEATURE_W = 16;     // Unsigned feature
	localparam int WEIGHT_W  = 8;      // Unsigned weight
	localparam int DOT_W     = 24;     // Result kept modulo 2^DOT_W

	// Pipeline depths seen from the top level ports
	localparam int MUL_LATENCY = 5;
	localparam int DOT_LATENCY = 3;

	// One bfloat16 number
	typedef struct packed {
		logic                  sign;
		logic [BF16_EXP_W-1:0] exp;
		logic [BF16_MAN_W-1:0] man;
	} bf16_t;

	// Operand classification, any_exc on top
	typedef struct packed {
		logic any_exc;
		logic a_nan;
		logic b_nan;
		logic a_inf;
		logic b_inf;
	} mul_flags_t;

	// One feature/weight pair
	typedef struct packed {
		logic [FEATURE_W-1:0] feature;
		logic [WEIGHT_W-1:0]  weight;
	} lane_t;

	typedef logic [DOT_W-1:0] dot_result_t;

endpackage

`default_nettype wire

//--- hw/bf16_mul.sv
`timescale 1ns/1ps
`default_nettype none

module bf16_mul (
	input  logic                clk,
	input  logic                reset,
	input  dsp_pkg::bf16_t      i_a,
	input  dsp_pkg::bf16_t      i_b,
	output dsp_pkg::bf16_t      o_result,
	output dsp_pkg::mul_flags_t o_flags
);
	import dsp_pkg::*;

	localparam int PROD_W = 2 * (BF16_MAN_W + 1);   // 8x8 mantissa product

	// Prepare stage contents
	typedef struct packed {
		logic                sign;
		logic [BF16_EXP_W:0] exp_sum;   // Raw sum, bias still in
		logic [PROD_W-1:0]   prod;      // 2.14 fixed point
		mul_flags_t          flags;
	} prep_t;

	// Execute stage contents
	typedef struct packed {
		logic                  sign;
		logic [BF16_EXP_W-1:0] exp;
		logic [BF16_MAN_W-1:0] man;
		logic                  guard;   // First dropped bit
		logic                  rnd;     // Second dropped bit
		logic                  sticky;  // OR of the rest
		mul_flags_t            flags;
	} exec_t;

	// Round and output stage contents
	typedef struct packed {
		bf16_t      res;
		mul_flags_t flags;
	} round_t;

	bf16_t  a_q;
	bf16_t  b_q;
	prep_t  prep_d, prep_q;
	exec_t  exec_d, exec_q;
	round_t round_d, round_q;
	round_t out_q;
	logic [1:0] fill;   // Stage 1 and stage 2 hold sampled data

	logic                  norm;
	logic [BF16_EXP_W:0]   exp_full;
	logic                  round_up;
	logic [BF16_MAN_W+1:0] man_inc;   // Carry, hidden one, mantissa

	function automatic mul_flags_t classify(bf16_t a, bf16_t b);
		mul_flags_t f;
		f.a_nan   = (&a.exp) & (|a.man);
		f.b_nan   = (&b.exp) & (|b.man);
		f.a_inf   = (&a.exp) & ~(|a.man);
		f.b_inf   = (&b.exp) & ~(|b.man);
		f.any_exc = f.a_nan | f.b_nan | f.a_inf | f.b_inf;
		return f;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Prepare
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		prep_d.sign    = a_q.sign ^ b_q.sign;
		prep_d.exp_sum = {1'b0, a_q.exp} + {1'b0, b_q.exp};
		prep_d.prod    = {1'b1, a_q.man} * {1'b1, b_q.man};   // Hidden ones back in
		prep_d.flags   = classify(a_q, b_q);
	end

	//////////////////////////////////////////////////////////////////////
	// Execute
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		norm          = prep_q.prod[PROD_W-1];   // Product in [2,4)
		exp_full      = prep_q.exp_sum + (BF16_EXP_W+1)'(norm)
			- (BF16_EXP_W+1)'(BF16_BIAS);
		exec_d.sign   = prep_q.sign;
		exec_d.exp    = exp_full[BF16_EXP_W-1:0];   // Wraps, no over/underflow
		exec_d.flags  = prep_q.flags;
		if (norm) begin
			exec_d.man    = prep_q.prod[PROD_W-2 -: BF16_MAN_W];
			exec_d.guard  = prep_q.prod[BF16_MAN_W];
			exec_d.rnd    = prep_q.prod[BF16_MAN_W-1];
			exec_d.sticky = |prep_q.prod[BF16_MAN_W-2:0];
		end else begin
			exec_d.man    = prep_q.prod[PROD_W-3 -: BF16_MAN_W];
			exec_d.guard  = prep_q.prod[BF16_MAN_W-1];
			exec_d.rnd    = prep_q.prod[BF16_MAN_W-2];
			exec_d.sticky = |prep_q.prod[BF16_MAN_W-3:0];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Round to nearest even
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		// Above half, or exactly half with odd LSB
		round_up          = exec_q.guard & (exec_q.rnd | exec_q.sticky | exec_q.man[0]);
		man_inc           = {2'b01, exec_q.man} + (BF16_MAN_W+2)'(round_up);
		round_d.res.sign  = exec_q.sign;
		round_d.res.exp   = exec_q.exp + BF16_EXP_W'(man_inc[BF16_MAN_W+1]);
		round_d.flags     = exec_q.flags;
		if (man_inc[BF16_MAN_W+1])
			round_d.res.man = man_inc[BF16_MAN_W:1];   // Renormalize after carry
		else
			round_d.res.man = man_inc[BF16_MAN_W-1:0];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			a_q     <= '0;
			b_q     <= '0;
			prep_q  <= '0;
			exec_q  <= '0;
			round_q <= '0;
			out_q   <= '0;
			fill    <= '0;
		end else begin
			a_q     <= i_a;
			b_q     <= i_b;
			fill    <= {fill[0], 1'b1};
			// Empty stages pass zeros, keeps outputs clear until data lands
			prep_q  <= fill[0] ? prep_d : '0;
			exec_q  <= fill[1] ? exec_d : '0;
			round_q <= round_d;
			out_q   <= round_q;
		end
	end

	assign o_result = out_q.res;
	assign o_flags  = out_q.flags;

	// Summary flag built in prepare must still match after four more stages
	a_any_exc: assert property (@(posedge clk) disable iff (reset)
		o_flags.any_exc == (o_flags.a_nan | o_flags.b_nan | o_flags.a_inf | o_flags.b_inf));

endmodule

`default_nettype wire

//--- hw/pair_mac.sv
`timescale 1ns/1ps
`default_nettype none

module pair_mac #(
	parameter int RESULT_W = dsp_pkg::DOT_W
) (
	input  logic              clk,
	input  logic              reset,
	input  dsp_pkg::lane_t    i_lane_x,
	input  dsp_pkg::lane_t    i_lane_y,
	output logic [RESULT_W:0] o_sum
);
	import dsp_pkg::*;

	localparam int PROD_W = FEATURE_W + WEIGHT_W;   // Full unsigned product

	//////////////////////////////////////////////////////////////////////
	// Input registers
	//////////////////////////////////////////////////////////////////////

	lane_t lane_x_q;
	lane_t lane_y_q;

	logic [PROD_W-1:0] prod_x;
	logic [PROD_W-1:0] prod_y;

	assign prod_x = lane_x_q.feature * lane_x_q.weight;
	assign prod_y = lane_y_q.feature * lane_y_q.weight;

	always_ff @(posedge clk) begin
		if (reset) begin
			lane_x_q <= '0;
			lane_y_q <= '0;
			o_sum    <= '0;
		end else begin
			lane_x_q <= i_lane_x;   // Edge N+1
			lane_y_q <= i_lane_y;
			// Pair sum at edge N+2, one extra bit for the carry
			o_sum    <= (RESULT_W+1)'(prod_x) + (RESULT_W+1)'(prod_y);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	// Zero input regs after reset must not leave a stale sum behind
	a_sum_clear: assert property (@(posedge clk) $fell(reset) |=> o_sum == '0);

endmodule

`default_nettype wire

//--- hw/chain_adder.sv
`timescale 1ns/1ps
`default_nettype none

module chain_adder #(
	parameter int RESULT_W = dsp_pkg::DOT_W
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic [RESULT_W:0]    i_sum_lo,
	input  logic [RESULT_W:0]    i_sum_hi,
	output dsp_pkg::dot_result_t o_result
);
	import dsp_pkg::*;

	logic [RESULT_W:0] sum_full;   // Lanes 0..3 combined

	assign sum_full = i_sum_lo + i_sum_hi;

	always_ff @(posedge clk) begin
		if (reset)
			o_result <= '0;
		else
			o_result <= dot_result_t'(sum_full[RESULT_W-1:0]);   // Modulo 2^RESULT_W
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	// Pair units clear too, so the first result after reset is zero
	a_result_clear: assert property (@(posedge clk) $fell(reset) |=> o_result == '0);

endmodule

`default_nettype wire

//--- hw/dsp_regression_top.sv
`timescale 1ns/1ps
`default_nettype none

module dsp_regression_top #(
	parameter int RESULT_W = dsp_pkg::DOT_W
) (
	input  logic                      clk,
	input  logic                      reset,
	input  dsp_pkg::bf16_t            i_a,
	input  dsp_pkg::bf16_t            i_b,
	input  dsp_pkg::lane_t [3:0]      i_lanes,
	output dsp_pkg::bf16_t            o_mul_result,
	output dsp_pkg::mul_flags_t       o_mul_flags,
	output dsp_pkg::dot_result_t      o_dot_result
);

	//////////////////////////////////////////////////////////////////////
	// bfloat16 multiplier, 5 cycles
	//////////////////////////////////////////////////////////////////////

	bf16_mul u_mul (
		.clk      (clk),
		.reset    (reset),
		.i_a      (i_a),
		.i_b      (i_b),
		.o_result (o_mul_result),
		.o_flags  (o_mul_flags)
	);

	//////////////////////////////////////////////////////////////////////
	// Four lane dot product, 3 cycles
	//////////////////////////////////////////////////////////////////////

	logic [RESULT_W:0] sum_lo;   // Lanes 0 and 1
	logic [RESULT_W:0] sum_hi;   // Lanes 2 and 3

	pair_mac #(.RESULT_W(RESULT_W)) u_pair_lo (
		.clk      (clk),
		.reset    (reset),
		.i_lane_x (i_lanes[0]),
		.i_lane_y (i_lanes[1]),
		.o_sum    (sum_lo)
	);

	pair_mac #(.RESULT_W(RESULT_W)) u_pair_hi (
		.clk      (clk),
		.reset    (reset),
		.i_lane_x (i_lanes[2]),
		.i_lane_y (i_lanes[3]),
		.o_sum    (sum_hi)
	);

	chain_adder #(.RESULT_W(RESULT_W)) u_chain (
		.clk      (clk),
		.reset    (reset),
		.i_sum_lo (sum_lo),
		.i_sum_hi (sum_hi),
		.o_result (o_dot_result)
	);

endmodule

`default_nettype wire

//--- bench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int HALF_PERIOD = 10   // ns, full period 20 ns
) (
	output logic o_clk
);

	initial begin
		o_clk = 1'b0;
		forever #(HALF_PERIOD) o_clk = ~o_clk;
	end

endmodule

`default_nettype wire

//--- bench/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;
	import dsp_pkg::*;

	localparam int RESET_TIMEOUT = 20;   // Cycles allowed for reset release
	localparam int N_RANDOM      = 300;
	localparam int N_EDGE        = 8;    // Rounding edge pairs in the table
	localparam int N_EXC         = 60;

	logic        clk;
	logic        reset;
	bf16_t       a;
	bf16_t       b;
	lane_t [3:0] lanes;
	bf16_t       mul_result;
	mul_flags_t  mul_flags;
	dot_result_t dot_result;

	logic [31:0] rng_state = 32'hd751;

	// Expected values, head lines up with the current outputs
	bf16_t       mul_q[$];
	logic        mul_chk_q[$];   // Low when an operand is NaN or infinity
	mul_flags_t  flags_q[$];
	dot_result_t dot_q[$];

	// Mantissa pairs landing exactly halfway or carrying past the hidden one
	logic [6:0] edge_man_a [N_EDGE] = '{7'h40, 7'h40, 7'h40, 7'h40, 7'h01, 7'h02, 7'h03, 7'h35};
	logic [6:0] edge_man_b [N_EDGE] = '{7'h01, 7'h03, 7'h2e, 7'h32, 7'h7e, 7'h7c, 7'h7a, 7'h35};

	tb_clock u_clock (.o_clk(clk));

	dsp_regression_top #(.RESULT_W(DOT_W)) uut (
		.clk          (clk),
		.reset        (reset),
		.i_a          (a),
		.i_b          (b),
		.i_lanes      (lanes),
		.o_mul_result (mul_result),
		.o_mul_flags  (mul_flags),
		.o_dot_result (dot_result)
	);

	//////////////////////////////////////////////////////////////////////
	// Random numbers and reference models
	//////////////////////////////////////////////////////////////////////

	function automatic logic [15:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state[31:16];   // High half, better period
	endfunction

	// Product from the format rules, exponent kept modulo 2^8
	function automatic bf16_t ref_product(bf16_t x, bf16_t y);
		bf16_t       r;
		int unsigned prod;
		int unsigned kept;
		int unsigned dropped;
		int unsigned half;
		int          shift;
		int          e;
		prod = 32'({1'b1, x.man}) * 32'({1'b1, y.man});   // Hidden ones included
		e    = int'(x.exp) + int'(y.exp) - BF16_BIAS;
		shift = (prod >= 32'h8000) ? 8 : 7;   // Product in [2,4) drops one more bit
		if (shift == 8)
			e = e + 1;
		kept    = prod >> shift;
		dropped = prod - (kept << shift);
		half    = 32'd1 << (shift - 1);
		if (dropped > half || (dropped == half && kept[0]))
			kept = kept + 1;   // Nearest, ties to even
		if (kept == 32'd256) begin
			kept = kept >> 1;   // Mantissa overflow
			e    = e + 1;
		end
		r.sign = x.sign ^ y.sign;
		r.exp  = e[7:0];
		r.man  = kept[6:0];
		return r;
	endfunction

	function automatic mul_flags_t classify_operands(bf16_t x, bf16_t y);
		mul_flags_t f;
		f.a_nan   = (x.exp == 8'hff) && (x.man != 7'd0);
		f.b_nan   = (y.exp == 8'hff) && (y.man != 7'd0);
		f.a_inf   = (x.exp == 8'hff) && (x.man == 7'd0);
		f.b_inf   = (y.exp == 8'hff) && (y.man == 7'd0);
		f.any_exc = f.a_nan || f.b_nan || f.a_inf || f.b_inf;
		return f;
	endfunction

	function automatic dot_result_t dot_sum(lane_t [3:0] l);
		longint unsigned sum;
		int              i;
		sum = 0;
		for (i = 0; i < 4; i++)
			sum = sum + 64'(l[i].feature) * 64'(l[i].weight);
		return dot_result_t'(sum % (64'd1 << DOT_W));   // Modulo 2^24
	endfunction

	function automatic bf16_t finite_operand();
		bf16_t       x;
		logic [15:0] r;
		r      = next_rand();
		x.sign = r[15];
		x.man  = r[6:0];
		x.exp  = 8'(64 + (next_rand() % 127));   // 64..190
		return x;
	endfunction

	function automatic bf16_t exc_operand();
		bf16_t       x;
		logic [15:0] r;
		r      = next_rand();
		x.sign = r[15];
		x.exp  = 8'hff;
		x.man  = (r[9:8] == 2'd0) ? 7'd0 : r[6:0];   // Some infinities
		return x;
	endfunction

	function automatic lane_t [3:0] random_lanes(int n);
		lane_t [3:0] l;
		logic [15:0] r;
		int          i;
		for (i = 0; i < 4; i++) begin
			r             = next_rand();
			l[i].feature  = (n % 16 == 0) ? 16'hffff : next_rand();
			l[i].weight   = (n % 16 == 0) ? 8'hff : r[12:5];   // All-max every 16th set
		end
		return l;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	task automatic stop_with_failure(string why);
		$display("Something failed");
		$fatal(1, "%s", why);
	endtask

	task automatic check_mul(bf16_t got, bf16_t want);
		if (got !== want) begin
			$display("[FAIL] %0t ns o_mul_result got %h expected %h", $time, got, want);
			stop_with_failure("product mismatch");
		end
	endtask

	task automatic check_flags(mul_flags_t got, mul_flags_t want);
		if (got !== want) begin
			$display("[FAIL] %0t ns o_mul_flags got %b expected %b", $time, got, want);
			stop_with_failure("flag mismatch");
		end
	endtask

	task automatic check_dot(dot_result_t got, dot_result_t want);
		if (got !== want) begin
			$display("[FAIL] %0t ns o_dot_result got %h expected %h", $time, got, want);
			stop_with_failure("dot product mismatch");
		end
	endtask

	// Outputs stay clear while reset is high
	task automatic wait_reset_release();
		int n;
		n = 0;
		@(negedge clk);
		while (reset) begin
			check_mul(mul_result, '0);
			check_flags(mul_flags, '0);
			check_dot(dot_result, '0);
			n = n + 1;
			if (n > RESET_TIMEOUT) begin
				$display("Reset was not released within %0d cycles", RESET_TIMEOUT);
				stop_with_failure("reset timeout");
			end
			@(negedge clk);
		end
	endtask

	// Called on a falling edge, ends on the next one
	task automatic run_cycle(bf16_t next_a, bf16_t next_b, lane_t [3:0] next_lanes);
		mul_flags_t f;
		bf16_t      want_mul;
		logic       want_chk;
		f = classify_operands(a, b);   // Inputs taken at the last rising edge
		mul_q.push_back(ref_product(a, b));
		mul_chk_q.push_back(!f.any_exc);
		flags_q.push_back(f);
		dot_q.push_back(dot_sum(lanes));
		want_mul = mul_q.pop_front();
		want_chk = mul_chk_q.pop_front();
		if (want_chk)
			check_mul(mul_result, want_mul);
		check_flags(mul_flags, flags_q.pop_front());
		check_dot(dot_result, dot_q.pop_front());
		a     = next_a;
		b     = next_b;
		lanes = next_lanes;
		@(negedge clk);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Reset and stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset <= 1'b0;
	end

	initial begin
		bf16_t       na;
		bf16_t       nb;
		int          i;
		reset = 1'b1;
		a     = '0;
		b     = '0;
		lanes = '0;
		// Pipelines hold zeros until the first sample lands
		// Input stage already taken when a cycle is modeled
		for (i = 0; i < MUL_LATENCY - 1; i++) begin
			mul_q.push_back('0);
			mul_chk_q.push_back(1'b1);
			flags_q.push_back('0);
		end
		for (i = 0; i < DOT_LATENCY - 1; i++)
			dot_q.push_back('0);
		wait_reset_release();

		for (i = 0; i < N_RANDOM; i++) begin
			na = finite_operand();
			nb = finite_operand();
			run_cycle(na, nb, random_lanes(i));
		end

		// Halfway and overflow cases, both operand orders
		for (i = 0; i < 2 * N_EDGE; i++) begin
			na     = finite_operand();
			nb     = finite_operand();
			na.man = (i < N_EDGE) ? edge_man_a[i % N_EDGE] : edge_man_b[i % N_EDGE];
			nb.man = (i < N_EDGE) ? edge_man_b[i % N_EDGE] : edge_man_a[i % N_EDGE];
			run_cycle(na, nb, random_lanes(i));
		end

		for (i = 0; i < N_EXC; i++) begin
			na = (i % 3 == 1) ? finite_operand() : exc_operand();
			nb = (i % 3 == 0) ? finite_operand() : exc_operand();
			run_cycle(na, nb, random_lanes(i));
		end

		// Drain the pipelines
		for (i = 0; i <= MUL_LATENCY; i++)
			run_cycle('0, '0, '0);

		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- dsp_regression.f
hw/dsp_pkg.sv
hw/bf16_mul.sv
hw/pair_mac.sv
hw/chain_adder.sv
hw/dsp_regression_top.sv
bench/tb_clock.sv
bench/tb_top.sv

//--- run_sim.sh
#!/bin/sh
# Build tb_top with Verilator and run it; pass only if the banner line shows up

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_top --Mdir obj_dir -o tb_top_sim \
	-f dsp_regression.f || { echo "Build failed"; exit 1; }

./obj_dir/tb_top_sim | tee /dev/stderr | grep -qx "Everything OK" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
